//--- project.f
+incdir+source
source/gfxPkg.sv
source/gfxIfs.sv
source/cpuRegisterFile.sv
source/spanWalker.sv
source/drawSequencer.sv
source/displayOutputs.sv
source/graphicsController.sv
test/graphicsController_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f project.f \
	--top-module graphicsController_tb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Simulation passed" &&
echo "RUN OK" || { echo "RUN NOT OK"; exit 1; }

//--- source/cpuRegisterFile.sv
`default_nettype none
`include "gfx_defs.svh"

module cpuRegisterFile (
	input wire logic Clk,
	input wire logic rstN,
	input wire gfxPkg::regWord_t AddressIn,
	input wire gfxPkg::regWord_t DataInFromCPU,
	input wire logic AS_L,
	input wire logic UDS_L,
	input wire logic LDS_L,
	input wire logic RW,
	input wire logic GraphicsCS_L,
	input wire gfxPkg::pixel_t colourLatch,
	output gfxPkg::regWord_t DataOutToCPU,
	drawRegsIf.regs regs
);
	import gfxPkg::*;

	logic inWindow;	// 0x00xx
	logic writeSel, readSel;
	logic [6:0] offset;
	logic selCommand, selX1, selY1, selX2, selY2, selColour;
	logic idle;	// status bit 0

	// byte-laned update, a lane changes only when its strobe is low
	function automatic regWord_t mergeLanes(input regWord_t old, input regWord_t wr,
		input logic udsL, input logic ldsL);
		regWord_t merged;
		merged = old;
		if (!udsL)
			merged[15:8] = wr[15:8];
		if (!ldsL)
			merged[7:0] = wr[7:0];
		return merged;
	endfunction

	assign offset = AddressIn[7:1];
	assign inWindow = !GraphicsCS_L && !AS_L && (AddressIn[15:8] == 8'h00);
	assign writeSel = inWindow && !RW;
	assign readSel = inWindow && RW;

	assign selCommand = writeSel && (offset == `GFX_OFS_COMMAND);
	assign selX1 = writeSel && (offset == `GFX_OFS_X1);
	assign selY1 = writeSel && (offset == `GFX_OFS_Y1);
	assign selX2 = writeSel && (offset == `GFX_OFS_X2);
	assign selY2 = writeSel && (offset == `GFX_OFS_Y2);
	assign selColour = writeSel && (offset == `GFX_OFS_COLOUR);

	//////////////////////////////////////////////////////////////////////////////
	// drawing registers
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regs.x1 <= '0;
			regs.y1 <= '0;
			regs.x2 <= `GFX_X2_RESET;	// past the right edge
			regs.y2 <= `GFX_Y2_RESET;
			regs.colour <= `GFX_COLOUR_RESET;
			regs.command <= '0;
		end else begin
			if (selX1)
				regs.x1 <= mergeLanes(regs.x1, DataInFromCPU, UDS_L, LDS_L);
			if (selY1)
				regs.y1 <= mergeLanes(regs.y1, DataInFromCPU, UDS_L, LDS_L);
			if (selX2)
				regs.x2 <= mergeLanes(regs.x2, DataInFromCPU, UDS_L, LDS_L);
			if (selY2)
				regs.y2 <= mergeLanes(regs.y2, DataInFromCPU, UDS_L, LDS_L);
			if (selColour)
				regs.colour <= mergeLanes(regs.colour, DataInFromCPU, UDS_L, LDS_L);
			if (selCommand)
				regs.command <= mergeLanes(regs.command, DataInFromCPU, UDS_L, LDS_L);
		end
	end

	// command flag, idle flag and cursor load pulses
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regs.commandWritten <= 1'b0;
			regs.loadX1 <= 1'b0;
			regs.loadY1 <= 1'b0;
			idle <= 1'b1;
		end else begin
			regs.loadX1 <= selX1;	// late by one, X1 already holds the new value
			regs.loadY1 <= selY1;
			if (selCommand)
				regs.commandWritten <= 1'b1;
			else if (regs.clearCommand)
				regs.commandWritten <= 1'b0;
			if (regs.setBusy)
				idle <= 1'b0;
			else if (regs.clearBusy)
				idle <= 1'b1;
		end
	end

	// read side: status at 0, colour latch at 0x0E
	always_comb begin
		DataOutToCPU = '0;
		if (readSel) begin
			if (offset == `GFX_OFS_COMMAND)
				DataOutToCPU = {15'b0, idle};
			else if (offset == `GFX_OFS_COLOUR)
				DataOutToCPU = {8'b0, colourLatch};	// zero extended
		end
	end

endmodule

`default_nettype wire

//--- source/displayOutputs.sv
`default_nettype none

module displayOutputs (
	input wire logic Clk,
	input wire logic rstN,
	pixelReqIf.sink req,
	input wire logic captureRead,
	input wire logic upperSel,
	input wire logic [15:0] SRam_DataIn,
	input wire logic paletteWe,
	input wire gfxPkg::paletteAddr_t colourIndex,
	input wire gfxPkg::rgb_t paletteRgb,
	output gfxPkg::pixel_t colourLatch,
	output logic [17:0] Sram_AddressOut,
	output logic [15:0] Sram_DataOut,
	output logic Sram_UDS_Out_L,
	output logic Sram_LDS_Out_L,
	output logic Sram_RW_Out,
	output gfxPkg::paletteAddr_t ColourPalletteAddr,
	output gfxPkg::rgb_t ColourPalletteData,
	output logic ColourPallette_WE_H
);
	import gfxPkg::*;

	pixel_t readByte;	// pixel picked out of the read word

	assign readByte = upperSel ? SRam_DataIn[15:8] : SRam_DataIn[7:0];

	// strobes and write enables, idle after reset
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			Sram_UDS_Out_L <= 1'b1;
			Sram_LDS_Out_L <= 1'b1;
			Sram_RW_Out <= 1'b1;
			ColourPallette_WE_H <= 1'b0;
		end else begin
			Sram_UDS_Out_L <= req.upperL;
			Sram_LDS_Out_L <= req.lowerL;
			Sram_RW_Out <= req.rw;
			ColourPallette_WE_H <= paletteWe;	// one cycle pulse
		end
	end

	// address, data and the read latch
	always_ff @(posedge Clk) begin
		Sram_AddressOut <= req.addr.flat;
		Sram_DataOut <= {req.data, req.data};
		ColourPalletteAddr <= colourIndex;
		ColourPalletteData <= paletteRgb;
		if (captureRead)
			colourLatch <= readByte;
	end

endmodule

`default_nettype wire

//--- source/drawSequencer.sv
`default_nettype none
`include "gfx_defs.svh"

module drawSequencer (
	input wire logic Clk,
	input wire logic rstN,
	input wire logic AS_L,
	input wire logic VSync_L,
	drawRegsIf.seq regs,
	input wire logic hDone,
	input wire logic vDone,
	input wire gfxPkg::fbAddr_t pixelAddr,
	input wire logic upperSel,
	output logic stepX,
	output logic stepY,
	pixelReqIf.src req,
	output logic captureRead,
	output logic paletteWe
);

	typedef enum logic [3:0] {
		Idle,
		ProcessCommand,
		DrawPixel,
		ReadPixel,
		ReadPixel1,
		ReadPixel2,
		DrawHLine,
		DrawVLine,
		PaletteProgram
	} state_t;

	state_t state, nextState;
	logic pixelWrite;	// single-lane write this cycle

	always_ff @(posedge Clk) begin
		if (!rstN)
			state <= Idle;
		else
			state <= nextState;
	end

	//////////////////////////////////////////////////////////////////////////////
	// next state and per-state access
	//////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = Idle;	// anything unknown falls back here
		pixelWrite = 1'b0;
		stepX = 1'b0;
		stepY = 1'b0;
		captureRead = 1'b0;
		paletteWe = 1'b0;
		regs.clearCommand = 1'b0;
		regs.setBusy = 1'b0;
		regs.clearBusy = 1'b0;

		req.addr = pixelAddr;
		req.data = regs.colour[7:0];	// repeated on both lanes downstream
		req.upperL = 1'b1;
		req.lowerL = 1'b1;
		req.rw = 1'b1;

		case (state)
			Idle: begin
				regs.clearBusy = 1'b1;
				if (regs.commandWritten && AS_L)	// cpu has released the bus
					nextState = ProcessCommand;
			end
			ProcessCommand: begin
				regs.setBusy = 1'b1;
				regs.clearCommand = 1'b1;
				case (regs.command)
					`GFX_CMD_PUTPIXEL: nextState = DrawPixel;
					`GFX_CMD_GETPIXEL: nextState = ReadPixel;
					`GFX_CMD_HLINE: nextState = DrawHLine;
					`GFX_CMD_VLINE: nextState = DrawVLine;
					`GFX_CMD_PALETTE: nextState = PaletteProgram;
					default: nextState = Idle;
				endcase
			end
			DrawPixel: begin
				pixelWrite = 1'b1;
			end
			ReadPixel: begin
				req.upperL = 1'b0;	// read the whole word
				req.lowerL = 1'b0;
				nextState = ReadPixel1;
			end
			ReadPixel1: begin
				nextState = ReadPixel2;	// sram latches the address here
			end
			ReadPixel2: begin
				captureRead = 1'b1;	// data is on SRam_DataIn now
			end
			DrawHLine: begin
				if (!hDone) begin
					pixelWrite = 1'b1;
					stepX = 1'b1;
					nextState = DrawHLine;
				end
			end
			DrawVLine: begin
				if (!vDone) begin
					pixelWrite = 1'b1;
					stepY = 1'b1;
					nextState = DrawVLine;
				end
			end
			PaletteProgram: begin
				// only touch the palette during vertical blanking
				if (!VSync_L)
					paletteWe = 1'b1;
				else
					nextState = PaletteProgram;
			end
			default: nextState = Idle;
		endcase

		if (pixelWrite) begin
			req.rw = 1'b0;
			req.upperL = !upperSel;
			req.lowerL = upperSel;
		end
	end

endmodule

`default_nettype wire

//--- source/gfxIfs.sv
`default_nettype none

// drawing registers from the cpu register file plus the status handshake back
interface drawRegsIf;
	import gfxPkg::*;

	coord_t x1, y1, x2, y2;
	regWord_t colour;
	command_t command;
	logic commandWritten;	// set by a cpu write to command
	logic loadX1, loadY1;	// one cycle after an X1 / Y1 write
	logic clearCommand;
	logic setBusy, clearBusy;

	modport regs(output x1, y1, x2, y2, colour, command, commandWritten, loadX1, loadY1,
		input clearCommand, setBusy, clearBusy);
	modport seq(input colour, command, commandWritten,
		output clearCommand, setBusy, clearBusy);
	modport walk(input x1, y1, x2, y2, commandWritten, loadX1, loadY1);
endinterface

// one frame buffer access per cycle, strobes active low
interface pixelReqIf;
	import gfxPkg::*;

	fbAddr_t addr;
	pixel_t data;	// copied to both byte lanes
	logic upperL;	// even column
	logic lowerL;	// odd column
	logic rw;	// 0 = write

	modport src(output addr, data, upperL, lowerL, rw);
	modport sink(input addr, data, upperL, lowerL, rw);
endinterface

`default_nettype wire

//--- source/gfxPkg.sv
`default_nettype none

package gfxPkg;

	typedef logic signed [15:0] coord_t;	// negative means off screen
	typedef logic [15:0] regWord_t;	// one cpu register word
	typedef logic [15:0] command_t;
	typedef logic [7:0] pixel_t;	// pixel value or palette index
	typedef logic [5:0] paletteAddr_t;	// 64 palette entries
	typedef logic [23:0] rgb_t;	// RRGGBB

	// frame buffer word address
	// each word holds two pixels, so a row has up to 512 column pairs
	typedef struct packed {
		logic [8:0] row;
		logic [8:0] columnPair;
	} fbRowCol_t;

	// same 18 bits, seen as row/pair fields or as the flat sram address
	typedef union packed {
		logic [17:0] flat;
		fbRowCol_t field;
	} fbAddr_t;

endpackage

`default_nettype wire

//--- source/gfx_defs.svh
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// register word offsets, decoded on AddressIn[7:1]
`define GFX_OFS_COMMAND 7'h00	// status on reads
`define GFX_OFS_X1 7'h01
`define GFX_OFS_Y1 7'h02
`define GFX_OFS_X2 7'h03
`define GFX_OFS_Y2 7'h04
`define GFX_OFS_COLOUR 7'h07	// colour latch on reads

// command codes written to the command register
`define GFX_CMD_HLINE 16'h0001
`define GFX_CMD_VLINE 16'h0002
`define GFX_CMD_PUTPIXEL 16'h000A
`define GFX_CMD_GETPIXEL 16'h000B
`define GFX_CMD_PALETTE 16'h0010

// visible area, lines stop at the first point outside
`define GFX_X_MAX 800
`define GFX_Y_MAX 480

// register values after reset
`define GFX_X2_RESET 16'd1024
`define GFX_Y2_RESET 16'd512
`define GFX_COLOUR_RESET 16'd4	// palette entry 4

`endif

//--- source/graphicsController.sv
`default_nettype none

module graphicsController (
	input wire logic Clk,
	input wire logic rstN,
	input wire gfxPkg::regWord_t AddressIn,
	input wire gfxPkg::regWord_t DataInFromCPU,
	input wire logic AS_L,
	input wire logic UDS_L,
	input wire logic LDS_L,
	input wire logic RW,
	input wire logic GraphicsCS_L,
	input wire logic VSync_L,	// palette writes wait for this low
	input wire logic [15:0] SRam_DataIn,
	output gfxPkg::regWord_t DataOutToCPU,
	output logic [17:0] Sram_AddressOut,
	output logic [15:0] Sram_DataOut,
	output logic Sram_UDS_Out_L,
	output logic Sram_LDS_Out_L,
	output logic Sram_RW_Out,
	output gfxPkg::paletteAddr_t ColourPalletteAddr,
	output gfxPkg::rgb_t ColourPalletteData,
	output logic ColourPallette_WE_H
);
	import gfxPkg::*;

	drawRegsIf drawRegs();
	pixelReqIf pixelReq();

	fbAddr_t pixelAddr;
	pixel_t colourLatch;
	logic upperSel;
	logic hDone, vDone;
	logic stepX, stepY;
	logic captureRead;
	logic paletteWe;

	cpuRegisterFile cpuRegisterFile_inst (
		.Clk(Clk), .rstN(rstN), .AddressIn(AddressIn), .DataInFromCPU(DataInFromCPU),
		.AS_L(AS_L), .UDS_L(UDS_L), .LDS_L(LDS_L), .RW(RW), .GraphicsCS_L(GraphicsCS_L),
		.colourLatch(colourLatch), .DataOutToCPU(DataOutToCPU), .regs(drawRegs.regs)
	);

	spanWalker spanWalker_inst (
		.Clk(Clk), .rstN(rstN), .regs(drawRegs.walk), .stepX(stepX), .stepY(stepY),
		.pixelAddr(pixelAddr), .upperSel(upperSel), .hDone(hDone), .vDone(vDone)
	);

	drawSequencer drawSequencer_inst (
		.Clk(Clk), .rstN(rstN), .AS_L(AS_L), .VSync_L(VSync_L), .regs(drawRegs.seq),
		.hDone(hDone), .vDone(vDone), .pixelAddr(pixelAddr), .upperSel(upperSel),
		.stepX(stepX), .stepY(stepY), .req(pixelReq.src), .captureRead(captureRead),
		.paletteWe(paletteWe)
	);

	// palette entry is Colour[5:0], value {X1[7:0], Y1}
	displayOutputs displayOutputs_inst (
		.Clk(Clk), .rstN(rstN), .req(pixelReq.sink), .captureRead(captureRead),
		.upperSel(upperSel), .SRam_DataIn(SRam_DataIn), .paletteWe(paletteWe),
		.colourIndex(drawRegs.colour[5:0]), .paletteRgb({drawRegs.x1[7:0], drawRegs.y1}),
		.colourLatch(colourLatch), .Sram_AddressOut(Sram_AddressOut),
		.Sram_DataOut(Sram_DataOut), .Sram_UDS_Out_L(Sram_UDS_Out_L),
		.Sram_LDS_Out_L(Sram_LDS_Out_L), .Sram_RW_Out(Sram_RW_Out),
		.ColourPalletteAddr(ColourPalletteAddr), .ColourPalletteData(ColourPalletteData),
		.ColourPallette_WE_H(ColourPallette_WE_H)
	);

endmodule

`default_nettype wire

//--- source/spanWalker.sv
`default_nettype none
`include "gfx_defs.svh"

module spanWalker (
	input wire logic Clk,
	input wire logic rstN,
	drawRegsIf.walk regs,
	input wire logic stepX,
	input wire logic stepY,
	output gfxPkg::fbAddr_t pixelAddr,
	output logic upperSel,
	output logic hDone,
	output logic vDone
);
	import gfxPkg::*;

	coord_t curX, curY;	// line cursor
	logic xOnScreen, yOnScreen;

	//////////////////////////////////////////////////////////////////////////////
	// cursor
	//////////////////////////////////////////////////////////////////////////////

	// reloads on an X1/Y1 write and again while a command waits to start,
	// so every command begins at (X1, Y1)
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			curX <= '0;
			curY <= '0;
		end else begin
			if (regs.loadX1 || regs.commandWritten)
				curX <= regs.x1;
			else if (stepX)
				curX <= curX + 16'sd1;	// hline walks right

			if (regs.loadY1 || regs.commandWritten)
				curY <= regs.y1;
			else if (stepY)
				curY <= curY + 16'sd1;	// vline walks down
		end
	end

	// clip test against the visible area
	assign xOnScreen = (curX >= 0) && (curX < `GFX_X_MAX);
	assign yOnScreen = (curY >= 0) && (curY < `GFX_Y_MAX);

	// end of span: reached X2 / Y2 (exclusive) or left the screen
	assign hDone = (curX >= regs.x2) || !xOnScreen || !yOnScreen;
	assign vDone = (curY >= regs.y2) || !xOnScreen || !yOnScreen;

	// row then column pair
	// curX only moves on hlines, so a vline addresses column X1
	always_comb begin
		pixelAddr.field.row = curY[8:0];
		pixelAddr.field.columnPair = curX[9:1];
	end

	assign upperSel = !curX[0];	// even column lives in the upper byte

endmodule

`default_nettype wire

//--- test/graphicsController_tb.sv
`default_nettype none
`include "gfx_defs.svh"

module graphicsController_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import gfxPkg::*;

	localparam int FbWords = 262144;	// 18-bit word address
	localparam int PollLimit = 200;	// status reads before giving up

	logic Clk = 1'b0;
	logic rstN;
	regWord_t AddressIn;
	regWord_t DataInFromCPU;
	regWord_t DataOutToCPU;
	logic AS_L, UDS_L, LDS_L, RW, GraphicsCS_L;
	logic VSync_L;
	logic [15:0] SRam_DataIn = '0;
	logic [17:0] Sram_AddressOut;
	logic [15:0] Sram_DataOut;
	logic Sram_UDS_Out_L, Sram_LDS_Out_L, Sram_RW_Out;
	paletteAddr_t ColourPalletteAddr;
	rgb_t ColourPalletteData;
	logic ColourPallette_WE_H;

	logic [15:0] sram [FbWords];	// frame buffer as the dut leaves it
	logic [15:0] refMem [FbWords];	// frame buffer as predicted
	logic preloadEn;	// backdoor write into the sram model
	logic [17:0] preloadAddr;
	logic [15:0] preloadData;
	int weCount;	// palette write pulses seen
	paletteAddr_t weAddr;
	rgb_t weData;

	graphicsController graphicsController_inst (.*);

	always #4 Clk = ~Clk;	// 8 ns period

	// start pattern, every address bit takes part
	function automatic logic [15:0] fillWord(input logic [17:0] a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h5a3};
	endfunction

	//////////////////////////////////////////////////////////////////////////////
	// sram and palette models
	//////////////////////////////////////////////////////////////////////////////

	always @(posedge Clk) begin
		SRam_DataIn <= sram[Sram_AddressOut];	// registered address, data one cycle on
		if (!rstN) begin
			for (int i = 0; i < FbWords; i++)
				sram[18'(i)] = fillWord(18'(i));
		end else if (preloadEn) begin
			sram[preloadAddr] = preloadData;
		end else if (Sram_RW_Out == 1'b0) begin
			if (!Sram_UDS_Out_L)
				sram[Sram_AddressOut][15:8] = Sram_DataOut[15:8];	// even column
			if (!Sram_LDS_Out_L)
				sram[Sram_AddressOut][7:0] = Sram_DataOut[7:0];
		end
	end

	// count palette write pulses, keep the last one
	always @(posedge Clk) begin
		if (!rstN) begin
			weCount <= 0;
		end else if (ColourPallette_WE_H) begin
			weCount <= weCount + 1;
			weAddr <= ColourPalletteAddr;
			weData <= ColourPalletteData;
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s at %0t", why, $time);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string what, input regWord_t actual, input regWord_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic checkPixel(input string what, input pixel_t actual, input pixel_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "run stopped");
		end
	endtask

	// whole frame buffer against the prediction
	task automatic compareMemories(input string after);
		for (int i = 0; i < FbWords; i++) begin
			if (sram[18'(i)] !== refMem[18'(i)])
				checkWord($sformatf("sram[%05h] after %s", i, after), sram[18'(i)],
					refMem[18'(i)]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// cpu bus, every task starts and ends 1 ns after a rising edge
	//////////////////////////////////////////////////////////////////////////////

	task automatic busWrite(input logic [6:0] offset, input regWord_t data);
		AddressIn = {8'h00, offset, 1'b0};
		DataInFromCPU = data;
		RW = 1'b0;
		UDS_L = 1'b0;	// both lanes
		LDS_L = 1'b0;
		GraphicsCS_L = 1'b0;
		AS_L = 1'b0;
		@(posedge Clk);
		#1;
		AS_L = 1'b1;
		GraphicsCS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		RW = 1'b1;
		@(posedge Clk);	// bus released for a cycle
		#1;
	endtask

	task automatic busRead(input logic [6:0] offset, output regWord_t data);
		AddressIn = {8'h00, offset, 1'b0};
		RW = 1'b1;
		GraphicsCS_L = 1'b0;
		AS_L = 1'b0;
		@(negedge Clk);
		data = DataOutToCPU;	// mid cycle, settled
		@(posedge Clk);
		#1;
		AS_L = 1'b1;
		GraphicsCS_L = 1'b1;
		@(posedge Clk);
		#1;
	endtask

	task automatic loadRegs(input int x1, input int y1, input int x2, input int y2,
		input regWord_t colour);
		busWrite(`GFX_OFS_X1, 16'(x1));
		busWrite(`GFX_OFS_Y1, 16'(y1));
		busWrite(`GFX_OFS_X2, 16'(x2));
		busWrite(`GFX_OFS_Y2, 16'(y2));
		busWrite(`GFX_OFS_COLOUR, colour);
	endtask

	task automatic preloadWord(input logic [17:0] a, input logic [15:0] data);
		preloadAddr = a;
		preloadData = data;
		preloadEn = 1'b1;
		@(posedge Clk);
		#1;
		preloadEn = 1'b0;
		refMem[a] = data;
	endtask

	// accepted at the edge after the write, busy one edge later
	task automatic startCommand(input command_t cmd);
		regWord_t status;
		busWrite(`GFX_OFS_COMMAND, cmd);
		@(posedge Clk);
		#1;
		busRead(`GFX_OFS_COMMAND, status);
		checkWord("status once the command is taken", status, 16'h0000);
	endtask

	task automatic waitIdle();
		regWord_t status;
		int polls;
		status = '0;
		polls = 0;
		while (status[0] !== 1'b1 && polls < PollLimit) begin
			busRead(`GFX_OFS_COMMAND, status);
			polls++;
		end
		if (status[0] !== 1'b1)
			abortRun("timed out waiting for status to return to idle");
		checkWord("status at the end of a command", status, 16'h0001);
	endtask

	task automatic runCommand(input command_t cmd);
		startCommand(cmd);
		waitIdle();
	endtask

	// row, then column pair
	function automatic logic [17:0] wordAddr(input int x, input int y);
		return {9'(y), 9'(x >> 1)};
	endfunction

	task automatic refPut(input int x, input int y, input pixel_t c);
		logic [17:0] a;
		a = wordAddr(x, y);
		if (x % 2 == 0)
			refMem[a][15:8] = c;
		else
			refMem[a][7:0] = c;
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////////////

	initial begin
		int x1, y1, x2, y2, pos;
		regWord_t colour, rd;
		logic [15:0] word;
		logic [17:0] a;
		pixel_t expPixel;

		void'($urandom(32'h24cc_d6d0));
		rstN = 1'b0;
		AddressIn = '0;
		DataInFromCPU = '0;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		RW = 1'b1;
		GraphicsCS_L = 1'b1;
		VSync_L = 1'b1;
		preloadEn = 1'b0;
		preloadAddr = '0;
		preloadData = '0;
		for (int i = 0; i < FbWords; i++)
			refMem[18'(i)] = fillWord(18'(i));
		repeat (10) @(posedge Clk);
		#1;
		rstN = 1'b1;

		// idle outputs and status after reset
		checkWord("UDS, LDS, RW after reset", {13'b0, Sram_UDS_Out_L, Sram_LDS_Out_L,
			Sram_RW_Out}, 16'h0007);
		checkWord("ColourPallette_WE_H after reset", {15'b0, ColourPallette_WE_H}, 16'h0000);
		busRead(`GFX_OFS_COMMAND, rd);
		checkWord("status after reset", rd, 16'h0001);
		compareMemories("reset");

		for (int n = 0; n < 8; n++) begin	// single pixels
			x1 = $urandom_range(0, `GFX_X_MAX - 1);
			y1 = $urandom_range(0, `GFX_Y_MAX - 1);
			colour = 16'($urandom);
			loadRegs(x1, y1, 1024, 512, colour);
			runCommand(`GFX_CMD_PUTPIXEL);
			refPut(x1, y1, colour[7:0]);
			compareMemories("PutPixel");
		end

		for (int n = 0; n < 6; n++) begin	// read back a preloaded word
			x1 = $urandom_range(0, `GFX_X_MAX - 1);
			y1 = $urandom_range(0, `GFX_Y_MAX - 1);
			a = wordAddr(x1, y1);
			word = 16'($urandom);
			preloadWord(a, word);
			loadRegs(x1, y1, 1024, 512, 16'($urandom));
			runCommand(`GFX_CMD_GETPIXEL);
			busRead(`GFX_OFS_COLOUR, rd);
			expPixel = (x1 % 2 == 0) ? word[15:8] : word[7:0];
			checkPixel("colour latch", rd[7:0], expPixel);
			checkPixel("colour read upper byte", rd[15:8], 8'h00);
			compareMemories("GetPixel");
		end

		for (int n = 0; n < 8; n++) begin	// hlines, some run off the right or bottom
			x1 = $urandom_range(0, 839);
			x2 = x1 + $urandom_range(0, 48);
			y1 = $urandom_range(0, 499);
			if (n == 0) begin	// straddles the right edge
				x1 = `GFX_X_MAX - 9;
				x2 = `GFX_X_MAX + 20;
			end else if (n == 1) begin	// row below the screen
				x1 = 100;
				x2 = 140;
				y1 = `GFX_Y_MAX + 2;
			end
			colour = 16'($urandom);
			loadRegs(x1, y1, x2, y1 + 1, colour);
			runCommand(`GFX_CMD_HLINE);
			pos = x1;
			while (pos < x2 && pos < `GFX_X_MAX && y1 < `GFX_Y_MAX) begin
				refPut(pos, y1, colour[7:0]);
				pos++;
			end
			compareMemories("Hline");
		end

		for (int n = 0; n < 8; n++) begin	// vlines
			x1 = $urandom_range(0, 839);
			y1 = $urandom_range(0, 499);
			y2 = y1 + $urandom_range(0, 48);
			if (n == 0) begin	// crosses the bottom edge
				y1 = `GFX_Y_MAX - 7;
				y2 = `GFX_Y_MAX + 25;
			end else if (n == 1) begin	// column right of the screen
				x1 = `GFX_X_MAX + 3;
				y1 = 10;
				y2 = 50;
			end
			colour = 16'($urandom);
			loadRegs(x1, y1, x1 + 1, y2, colour);
			runCommand(`GFX_CMD_VLINE);
			pos = y1;
			while (pos < y2 && pos < `GFX_Y_MAX && x1 < `GFX_X_MAX) begin
				refPut(x1, pos, colour[7:0]);
				pos++;
			end
			compareMemories("Vline");
		end

		// palette write held off until vertical sync
		x1 = $urandom_range(0, 255);
		y1 = $urandom_range(0, 65535);
		colour = 16'($urandom);
		loadRegs(x1, y1, 1024, 512, colour);
		startCommand(`GFX_CMD_PALETTE);
		for (int n = 0; n < 20; n++) begin
			busRead(`GFX_OFS_COMMAND, rd);
			checkWord("status while VSync_L is high", rd, 16'h0000);
		end
		checkWord("palette writes while VSync_L is high", 16'(weCount), 16'h0000);
		VSync_L = 1'b0;
		waitIdle();
		checkWord("palette writes after VSync_L low", 16'(weCount), 16'h0001);
		checkPixel("ColourPalletteAddr", {2'b00, weAddr}, {2'b00, colour[5:0]});
		checkPixel("ColourPalletteData[23:16]", weData[23:16], 8'(x1));
		checkWord("ColourPalletteData[15:0]", weData[15:0], 16'(y1));

		runCommand(16'h0055);	// not a command, straight back to idle
		compareMemories("unknown command");

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
